/* forthAlu.f */
+incdir+verilog
verilog/aluPkg.sv
verilog/aluOperandSelect.sv
verilog/aluCore.sv
verilog/conditionCodeLatch.sv
verilog/fullALU.sv
sim/fullALUTests.sv

/* Bender.yml */
package:
  name: forthAlu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/aluPkg.sv
      - verilog/aluOperandSelect.sv
      - verilog/aluCore.sv
      - verilog/conditionCodeLatch.sv
      - verilog/fullALU.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - sim/fullALUTests.sv

/* sim/fullALUTests.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module fullALUTests;

	import aluPkg::*;

	// ========================================
	// run length
	// ========================================
	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 5;
	localparam int IDLE_CYCLES   = 20;
	localparam int REG_CYCLES    = 400;
	localparam int IMM_CYCLES    = 200;
	localparam int FLAG_CYCLES   = 200;
	localparam int FORCE_CYCLES  = 100;
	localparam int SAVE_ROUNDS   = 20;
	localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + REG_CYCLES + IMM_CYCLES +
		FLAG_CYCLES + FORCE_CYCLES + SAVE_ROUNDS * 5;
	localparam int TIMEOUT_NS    = TOTAL_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD;

	logic       CLK;
	logic       reset;
	aluWord_t   regAData;
	aluWord_t   regBData;
	aluOp_t     aluOp;
	srcSel_t    aluASrc;
	srcSel_t    aluBSrc;
	logic [3:0] argA;
	logic [3:0] argB;
	logic       b5;
	logic       ccLoad;
	logic       ccEnR;
	logic       ccEn0;
	logic       ccEn1;
	ccMode_t    ccMode;
	aluWord_t   aluResult;
	logic       ccZero;
	logic       ccCarry;
	logic       ccSign;
	logic       ccParity;
	aluWord_t   aluAData;
	aluWord_t   aluBData;

	ccFlags_t   modelFlags;
	ccFlags_t   modelShadow;
	ccFlags_t   expNext;
	ccFlags_t   savedFlags;

	fullALU i_fullALU (
		.CLK       (CLK),
		.reset     (reset),
		.regAData  (regAData),
		.regBData  (regBData),
		.aluOp     (aluOp),
		.aluASrc   (aluASrc),
		.aluBSrc   (aluBSrc),
		.argA      (argA),
		.argB      (argB),
		.b5        (b5),
		.ccLoad    (ccLoad),
		.ccEnR     (ccEnR),
		.ccEn0     (ccEn0),
		.ccEn1     (ccEn1),
		.ccMode    (ccMode),
		.aluResult (aluResult),
		.ccZero    (ccZero),
		.ccCarry   (ccCarry),
		.ccSign    (ccSign),
		.ccParity  (ccParity),
		.aluAData  (aluAData),
		.aluBData  (aluBData)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Error: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	// ========================================
	// compare tasks
	// ========================================
	task automatic checkWord(input string testName, input string what,
		input aluWord_t expected, input aluWord_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s %s: expected %h actual %h", testName, what, expected, actual);
			$display("Testbench failed");
			$fatal(1, "word compare error");
		end
	endtask

	task automatic checkFlags(input string testName, input ccFlags_t expected,
		input ccFlags_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s flags: expected %b actual %b", testName, expected, actual);
			$display("Testbench failed");
			$fatal(1, "flag compare error");
		end
	endtask

	function automatic ccFlags_t currentFlags();
		ccFlags_t fl;
		fl.zero   = ccZero;
		fl.carry  = ccCarry;
		fl.sign   = ccSign;
		fl.parity = ccParity;
		return fl;
	endfunction

	// ========================================
	// reference model
	// ========================================
	// top byte filled with ones for a negative signed byte.
	function automatic aluWord_t byteImmediate(argField_t fld, logic sx);
		aluWord_t val;
		val = aluWord_t'(fld.imm);
		if (sx && fld.imm[7]) begin
			val[`ALU_WIDTH-1:8] = '1;
		end
		return val;
	endfunction

	function automatic aluWord_t modelOperandA(srcSel_t src, aluWord_t regVal,
		logic [3:0] hi, logic [3:0] lo, logic sx);
		argField_t fld;
		aluWord_t  val;
		fld.imm = {hi, lo};
		case (src)
			`ALUA_SRC_REG:    val = regVal;
			`ALUA_SRC_NIBBLE: val = aluWord_t'(fld.nib.high);
			`ALUA_SRC_BYTE:   val = byteImmediate(fld, sx);
			default:          val = '0; // zero source and spare codes.
		endcase
		return val;
	endfunction

	function automatic aluWord_t modelOperandB(srcSel_t src, aluWord_t regVal,
		logic [3:0] hi, logic [3:0] lo, logic sx);
		argField_t fld;
		aluWord_t  val;
		fld.imm = {hi, lo};
		val     = '0;
		case (src)
			`ALUB_SRC_REG:    val = regVal;
			`ALUB_SRC_NIBBLE: val = aluWord_t'(fld.nib.low);
			`ALUB_SRC_BYTE:   val = byteImmediate(fld, sx);
			`ALUB_SRC_ONE:    val = 1;
			`ALUB_SRC_BIT:    val[lo] = 1'b1;
			default:          val = '0;
		endcase
		return val;
	endfunction

	task automatic modelAlu(input aluWord_t a, input aluWord_t b, input aluOp_t op,
		input logic cin, output aluWord_t res, output ccFlags_t fl);
		int unsigned wide;
		logic        co;
		logic        par;
		co  = 1'b0;
		res = a;
		case (op)
			`ALU_OP_ADD, `ALU_OP_ADC: begin
				wide = 32'(a) + 32'(b) + ((op == `ALU_OP_ADC) ? cin : 1'b0);
				res  = wide[15:0];
				co   = wide[16];
			end
			`ALU_OP_SUB, `ALU_OP_SBC: begin
				wide = 32'(b) + ((op == `ALU_OP_SBC) ? cin : 1'b0);
				co   = (32'(a) < wide); // borrow.
				res  = a - wide[15:0];
			end
			`ALU_OP_AND:   res = a & b;
			`ALU_OP_OR:    res = a | b;
			`ALU_OP_XOR:   res = a ^ b;
			`ALU_OP_NOT:   res = ~a;
			`ALU_OP_SHL: begin
				res = a << 1;
				co  = a[15];
			end
			`ALU_OP_SHR: begin
				res = a >> 1;
				co  = a[0];
			end
			`ALU_OP_ROL: begin
				res = (a << 1) | aluWord_t'(cin);
				co  = a[15];
			end
			`ALU_OP_ROR: begin
				res = (a >> 1) | (aluWord_t'(cin) << 15);
				co  = a[0];
			end
			`ALU_OP_PASSB: res = b;
			default:       res = a; // passa and spare codes.
		endcase
		par = 1'b0;
		for (int i = 0; i < `ALU_WIDTH; i++) begin
			par = par ^ res[i];
		end
		fl.zero   = (res == 0);
		fl.carry  = co;
		fl.sign   = res[15];
		fl.parity = par;
	endtask

	task automatic updateModelLatch(input ccFlags_t nf);
		ccFlags_t oldFlags;
		oldFlags = modelFlags;
		if (ccLoad && ccMode != `CC_MODE_HOLD) begin
			if (ccMode == `CC_MODE_RESTORE) begin
				modelFlags = modelShadow;
			end else if (ccEnR) begin
				modelFlags = nf;
			end else if (ccEn0) begin
				modelFlags = '0;
			end else if (ccEn1) begin
				modelFlags = '1;
			end
			if (ccMode == `CC_MODE_SAVE) begin
				modelShadow = oldFlags;
			end
		end
	endtask

	// ========================================
	// stimulus
	// ========================================
	task automatic randomizeData();
		regAData = aluWord_t'($urandom);
		regBData = aluWord_t'($urandom);
		aluOp    = aluOp_t'($urandom);
		argA     = 4'($urandom);
		argB     = 4'($urandom);
		b5       = 1'($urandom);
	endtask

	task automatic setControls(input logic load, input logic enR, input logic en0,
		input logic en1, input ccMode_t mode);
		ccLoad = load;
		ccEnR  = enR;
		ccEn0  = en0;
		ccEn1  = en1;
		ccMode = mode;
	endtask

	// entered and left 2 ns after a rising edge.
	task automatic runCycle(input string testName);
		aluWord_t expA;
		aluWord_t expB;
		aluWord_t expRes;
		#(CLK_PERIOD - 4);
		expA = modelOperandA(aluASrc, regAData, argA, argB, b5);
		expB = modelOperandB(aluBSrc, regBData, argA, argB, b5);
		modelAlu(expA, expB, aluOp, modelFlags.carry, expRes, expNext);
		checkWord(testName, "aluAData", expA, aluAData);
		checkWord(testName, "aluBData", expB, aluBData);
		checkWord(testName, "aluResult", expRes, aluResult);
		checkFlags(testName, modelFlags, currentFlags());
		@(posedge CLK);
		updateModelLatch(expNext);
		#2;
	endtask

	initial begin
		void'($urandom(20));
		reset    = 1'b1;
		regAData = '0;
		regBData = '0;
		aluOp    = `ALU_OP_ADD;
		aluASrc  = `ALUA_SRC_REG;
		aluBSrc  = `ALUB_SRC_REG;
		argA     = '0;
		argB     = '0;
		b5       = 1'b0;
		setControls(1'b0, 1'b0, 1'b0, 1'b0, `CC_MODE_RUN);
		modelFlags  = '0;
		modelShadow = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2;
		reset = 1'b0;

		// flags stay clear while nothing loads.
		repeat (IDLE_CYCLES) begin
			randomizeData();
			aluASrc = srcSel_t'($urandom);
			aluBSrc = srcSel_t'($urandom);
			setControls(1'b0, 1'($urandom), 1'($urandom), 1'($urandom), ccMode_t'($urandom));
			runCycle("idleAfterReset");
		end

		repeat (REG_CYCLES) begin
			randomizeData();
			aluASrc = `ALUA_SRC_REG;
			aluBSrc = `ALUB_SRC_REG;
			setControls(1'($urandom), 1'b1, 1'b0, 1'b0, `CC_MODE_RUN);
			runCycle("registerOperands");
		end

		repeat (IMM_CYCLES) begin
			randomizeData();
			aluASrc = srcSel_t'($urandom);
			aluBSrc = srcSel_t'($urandom);
			setControls(1'($urandom), 1'b1, 1'b0, 1'b0, `CC_MODE_RUN);
			runCycle("immediateOperands");
		end

		repeat (FLAG_CYCLES) begin
			randomizeData();
			aluASrc = srcSel_t'($urandom);
			aluBSrc = srcSel_t'($urandom);
			setControls(1'($urandom), 1'b1, 1'($urandom), 1'($urandom), `CC_MODE_RUN);
			runCycle("flagLoad");
		end

		// clear and set with hold mode mixed in.
		repeat (FORCE_CYCLES) begin
			randomizeData();
			setControls(1'($urandom), 1'b0, 1'($urandom), 1'($urandom),
				($urandom % 2) ? `CC_MODE_HOLD : `CC_MODE_RUN);
			runCycle("forceFlags");
		end

		// ========================================
		// save and restore
		// ========================================
		repeat (SAVE_ROUNDS) begin
			randomizeData();
			aluASrc = `ALUA_SRC_REG;
			aluBSrc = `ALUB_SRC_REG;
			setControls(1'b1, 1'b1, 1'b0, 1'b0, `CC_MODE_RUN);
			runCycle("saveRestoreSetup");
			savedFlags = modelFlags;
			randomizeData();
			setControls(1'b1, 1'b1, 1'b0, 1'b0, `CC_MODE_SAVE);
			runCycle("saveRestoreSave");
			setControls(1'b1, 1'b0, savedFlags != '0, savedFlags == '0, `CC_MODE_RUN);
			runCycle("saveRestoreOverwrite");
			setControls(1'b1, 1'b1, 1'b0, 1'b0, `CC_MODE_RESTORE);
			runCycle("saveRestoreRestore");
			checkFlags("saveRestoreRestore", savedFlags, currentFlags());
			setControls(1'b0, 1'b0, 1'b0, 1'b0, `CC_MODE_RUN);
			runCycle("saveRestoreHold");
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

/* verilog/fullALU.sv */
`timescale 1ns/1ps

module fullALU (
	input  logic             CLK,
	input  logic             reset,
	input  aluPkg::aluWord_t regAData,
	input  aluPkg::aluWord_t regBData,
	input  aluPkg::aluOp_t   aluOp,
	input  aluPkg::srcSel_t  aluASrc,
	input  aluPkg::srcSel_t  aluBSrc,
	input  logic [3:0]       argA,
	input  logic [3:0]       argB,
	input  logic             b5,
	input  logic             ccLoad,
	input  logic             ccEnR,
	input  logic             ccEn0,
	input  logic             ccEn1,
	input  aluPkg::ccMode_t  ccMode,
	output aluPkg::aluWord_t aluResult,
	output logic             ccZero,
	output logic             ccCarry,
	output logic             ccSign,
	output logic             ccParity,
	output aluPkg::aluWord_t aluAData,
	output aluPkg::aluWord_t aluBData
);

	import aluPkg::*;

	ccFlags_t nextFlags;
	ccFlags_t ccFlags;

	// ========================================
	// operand selection
	// ========================================
	aluOperandSelect i_aluOperandSelect (
		.regAData (regAData),
		.regBData (regBData),
		.aluASrc  (aluASrc),
		.aluBSrc  (aluBSrc),
		.argA     (argA),
		.argB     (argB),
		.b5       (b5),
		.aluAData (aluAData),
		.aluBData (aluBData)
	);

	// ========================================
	// alu and flag latch
	// ========================================
	aluCore i_aluCore (
		.aluAData  (aluAData),
		.aluBData  (aluBData),
		.aluOp     (aluOp),
		.carryIn   (ccFlags.carry), // latched carry for adc/sbc/rotates.
		.aluResult (aluResult),
		.nextFlags (nextFlags)
	);

	conditionCodeLatch i_conditionCodeLatch (
		.CLK       (CLK),
		.reset     (reset),
		.ccLoad    (ccLoad),
		.ccEnR     (ccEnR),
		.ccEn0     (ccEn0),
		.ccEn1     (ccEn1),
		.ccMode    (ccMode),
		.nextFlags (nextFlags),
		.ccFlags   (ccFlags)
	);

	assign ccZero   = ccFlags.zero;
	assign ccCarry  = ccFlags.carry;
	assign ccSign   = ccFlags.sign;
	assign ccParity = ccFlags.parity;

endmodule

/* verilog/conditionCodeLatch.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module conditionCodeLatch (
	input  logic             CLK,
	input  logic             reset,
	input  logic             ccLoad,
	input  logic             ccEnR,
	input  logic             ccEn0,
	input  logic             ccEn1,
	input  aluPkg::ccMode_t  ccMode,
	input  aluPkg::ccFlags_t nextFlags,
	output aluPkg::ccFlags_t ccFlags
);

	import aluPkg::*;

	ccFlags_t flagReg;
	ccFlags_t shadowReg;
	logic     loadActive;
	logic     doSave;
	logic     doRestore;

	// ========================================
	// mode decode
	// ========================================
	assign loadActive = ccLoad && (ccMode != `CC_MODE_HOLD); // hold blocks everything.
	assign doSave     = loadActive && (ccMode == `CC_MODE_SAVE);
	assign doRestore  = loadActive && (ccMode == `CC_MODE_RESTORE);

	// ========================================
	// flag register
	// ========================================
	always_ff @(posedge CLK) begin
		if (reset) begin
			flagReg <= '0;
		end else if (doRestore) begin
			flagReg <= shadowReg; // restore wins.
		end else if (loadActive) begin
			if (ccEnR) begin
				flagReg <= nextFlags;
			end else if (ccEn0) begin
				flagReg <= '0;
			end else if (ccEn1) begin
				flagReg <= '1;
			end
		end
	end

	// shadow copy.
	always_ff @(posedge CLK) begin
		if (reset) begin
			shadowReg <= '0;
		end else if (doSave) begin
			shadowReg <= flagReg; // old flags, not the new load.
		end
	end

	assign ccFlags = flagReg;

endmodule

/* verilog/aluCore.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluCore (
	input  aluPkg::aluWord_t aluAData,
	input  aluPkg::aluWord_t aluBData,
	input  aluPkg::aluOp_t   aluOp,
	input  logic             carryIn,
	output aluPkg::aluWord_t aluResult,
	output aluPkg::ccFlags_t nextFlags
);

	import aluPkg::*;

	logic [`ALU_WIDTH:0] sumFull;
	logic [`ALU_WIDTH:0] diffFull;
	logic                addCarry;
	logic                subBorrow;
	aluWord_t            result;
	logic                carryOut;

	// ========================================
	// arithmetic
	// ========================================
	// adc and sbc pull in the latched carry.
	assign addCarry  = (aluOp == `ALU_OP_ADC) ? carryIn : 1'b0;
	assign subBorrow = (aluOp == `ALU_OP_SBC) ? carryIn : 1'b0;

	assign sumFull  = {1'b0, aluAData} + {1'b0, aluBData} + addCarry;
	assign diffFull = {1'b0, aluAData} - {1'b0, aluBData} - subBorrow;

	// ========================================
	// result and carry select
	// ========================================
	always_comb begin
		result   = aluAData;
		carryOut = 1'b0;
		case (aluOp)
			`ALU_OP_ADD,
			`ALU_OP_ADC: begin
				result   = sumFull[`ALU_WIDTH-1:0];
				carryOut = sumFull[`ALU_WIDTH];
			end
			`ALU_OP_SUB,
			`ALU_OP_SBC: begin
				result   = diffFull[`ALU_WIDTH-1:0];
				carryOut = diffFull[`ALU_WIDTH]; // borrow.
			end
			`ALU_OP_AND: result = aluAData & aluBData;
			`ALU_OP_OR:  result = aluAData | aluBData;
			`ALU_OP_XOR: result = aluAData ^ aluBData;
			`ALU_OP_NOT: result = ~aluAData;
			`ALU_OP_SHL: begin
				result   = {aluAData[`ALU_WIDTH-2:0], 1'b0};
				carryOut = aluAData[`ALU_WIDTH-1];
			end
			`ALU_OP_SHR: begin
				result   = {1'b0, aluAData[`ALU_WIDTH-1:1]};
				carryOut = aluAData[0];
			end
			`ALU_OP_ROL: begin
				result   = {aluAData[`ALU_WIDTH-2:0], carryIn}; // through carry.
				carryOut = aluAData[`ALU_WIDTH-1];
			end
			`ALU_OP_ROR: begin
				result   = {carryIn, aluAData[`ALU_WIDTH-1:1]};
				carryOut = aluAData[0];
			end
			`ALU_OP_PASSA: result = aluAData;
			`ALU_OP_PASSB: result = aluBData;
			default:       result = aluAData; // spare codes.
		endcase
	end

	// ========================================
	// flags
	// ========================================
	assign aluResult = result;

	assign nextFlags.zero   = (result == '0);
	assign nextFlags.carry  = carryOut;
	assign nextFlags.sign   = result[`ALU_WIDTH-1];
	assign nextFlags.parity = ^result;

endmodule

/* verilog/aluOperandSelect.sv */
`timescale 1ns/1ps
`include "alu_defines.svh"

module aluOperandSelect (
	input  aluPkg::aluWord_t regAData,
	input  aluPkg::aluWord_t regBData,
	input  aluPkg::srcSel_t  aluASrc,
	input  aluPkg::srcSel_t  aluBSrc,
	input  logic [3:0]       argA,
	input  logic [3:0]       argB,
	input  logic             b5,
	output aluPkg::aluWord_t aluAData,
	output aluPkg::aluWord_t aluBData
);

	import aluPkg::*;

	argField_t argField;
	aluWord_t  nibbleA;
	aluWord_t  nibbleB;
	aluWord_t  byteImm;
	aluWord_t  bitMask;

	// ========================================
	// immediate decode
	// ========================================
	assign argField.nib.high = argA;
	assign argField.nib.low  = argB;

	assign nibbleA = {{(`ALU_WIDTH-4){1'b0}}, argField.nib.high};
	assign nibbleB = {{(`ALU_WIDTH-4){1'b0}}, argField.nib.low};

	// b5 selects signed byte.
	assign byteImm = {{(`ALU_WIDTH-8){b5 & argField.imm[7]}}, argField.imm};

	assign bitMask = aluWord_t'(1) << argB; // single bit for test/set.

	// ========================================
	// operand muxes
	// ========================================
	always_comb begin
		case (aluASrc)
			`ALUA_SRC_REG:    aluAData = regAData;
			`ALUA_SRC_ZERO:   aluAData = '0;
			`ALUA_SRC_NIBBLE: aluAData = nibbleA;
			`ALUA_SRC_BYTE:   aluAData = byteImm;
			default:          aluAData = '0;
		endcase
	end

	always_comb begin
		case (aluBSrc)
			`ALUB_SRC_REG:    aluBData = regBData;
			`ALUB_SRC_NIBBLE: aluBData = nibbleB;
			`ALUB_SRC_BYTE:   aluBData = byteImm;
			`ALUB_SRC_ONE:    aluBData = aluWord_t'(1); // increment/decrement.
			`ALUB_SRC_BIT:    aluBData = bitMask;
			default:          aluBData = '0;
		endcase
	end

endmodule

/* verilog/aluPkg.sv */
`include "alu_defines.svh"

package aluPkg;

	// ========================================
	// data and control words
	// ========================================
	typedef logic [`ALU_WIDTH-1:0] aluWord_t;

	typedef logic [3:0] aluOp_t;

	typedef logic [2:0] srcSel_t;

	typedef logic [1:0] ccMode_t;

	// ========================================
	// condition flags
	// ========================================
	typedef struct packed {
		logic zero;
		logic carry;
		logic sign;
		logic parity;
	} ccFlags_t;

	// ========================================
	// instruction argument field
	// ========================================
	typedef struct packed {
		logic [3:0] high; // argA.
		logic [3:0] low;  // argB.
	} argNibbles_t;

	// same 8 bits seen as one byte or two nibbles.
	typedef union packed {
		logic [7:0]  imm;
		argNibbles_t nib;
	} argField_t;

endpackage

/* verilog/alu_defines.svh */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// ========================================
// data path
// ========================================
`define ALU_WIDTH 16

// ========================================
// alu operation codes
// ========================================
`define ALU_OP_ADD   4'd0
`define ALU_OP_ADC   4'd1
`define ALU_OP_SUB   4'd2
`define ALU_OP_SBC   4'd3
`define ALU_OP_AND   4'd4
`define ALU_OP_OR    4'd5
`define ALU_OP_XOR   4'd6
`define ALU_OP_NOT   4'd7
`define ALU_OP_SHL   4'd8
`define ALU_OP_SHR   4'd9
`define ALU_OP_ROL   4'd10
`define ALU_OP_ROR   4'd11
`define ALU_OP_PASSA 4'd12
`define ALU_OP_PASSB 4'd13

// ========================================
// operand sources
// ========================================
`define ALUA_SRC_REG    3'd0
`define ALUA_SRC_ZERO   3'd1
`define ALUA_SRC_NIBBLE 3'd2
`define ALUA_SRC_BYTE   3'd3

`define ALUB_SRC_REG    3'd0
`define ALUB_SRC_NIBBLE 3'd1
`define ALUB_SRC_BYTE   3'd2
`define ALUB_SRC_ONE    3'd3
`define ALUB_SRC_BIT    3'd4

// condition code latch modes.
`define CC_MODE_RUN     2'd0
`define CC_MODE_SAVE    2'd1
`define CC_MODE_RESTORE 2'd2
`define CC_MODE_HOLD    2'd3

`endif
